// ==== Makefile ====
TOP := tb_cache_wt_path

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f cache_wt_path.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== be_mem.sv ====
`timescale 1ns/10ps

module be_mem
   import cache_cfg_pkg::*;
#(
   parameter int MEM_ADDR_W = 6
) (
   input  logic                   clk_i,
   input  logic                   arst_i,

   // back-end write bus
   input  logic                   valid_i,
   input  logic [LINE_ADDR_W-1:0] addr_i,
   input  logic [BE_DATA_W-1:0]   wdata_i,
   input  logic [BE_NBYTES-1:0]   wstrb_i,
   output logic                   ready_o,

   input  logic                   stall_i, // external back-pressure

   // debug read
   input  logic [LINE_ADDR_W-1:0] dbg_addr_i,
   output logic [BE_DATA_W-1:0]   dbg_rdata_o
);

   localparam int NLINES = 2 ** MEM_ADDR_W;

   logic [BE_DATA_W-1:0] mem_q [NLINES];

   logic                  wr_en;
   logic [MEM_ADDR_W-1:0] wr_idx;
   logic [MEM_ADDR_W-1:0] dbg_idx;

   assign ready_o = ~stall_i;
   assign wr_en   = valid_i & ready_o;

   // upper line bits alias
   assign wr_idx  = addr_i[MEM_ADDR_W-1:0];
   assign dbg_idx = dbg_addr_i[MEM_ADDR_W-1:0];

   // cleared on reset so contents start from a known zero image
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         for (int l = 0; l < NLINES; l++) begin
            mem_q[l] <= '0;
         end
      end else if (wr_en) begin
         for (int b = 0; b < BE_NBYTES; b++) begin
            if (wstrb_i[b]) begin
               mem_q[wr_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
         end
      end
   end

   assign dbg_rdata_o = mem_q[dbg_idx];

endmodule

// ==== cache_cfg_pkg.sv ====
package cache_cfg_pkg;

   // front-end side, byte address and word
   localparam int FE_ADDR_W = 16;
   localparam int FE_DATA_W = 32;

   // back-end bus, one line per beat
   localparam int BE_DATA_W = 128;

   localparam int FE_NBYTES = FE_DATA_W / 8;
   localparam int BE_NBYTES = BE_DATA_W / 8;

   localparam int LANE_W = $clog2(BE_DATA_W / FE_DATA_W); // lane select bits

   localparam int FE_WADDR_W  = FE_ADDR_W - $clog2(FE_NBYTES); // word address
   localparam int LINE_ADDR_W = FE_WADDR_W - LANE_W;           // back-end line address

endpackage

// ==== cache_wt_path.f ====
cache_cfg_pkg.sv
wbuf_pkg.sv
wbuf_fifo.sv
wr_channel.sv
be_mem.sv
cache_wt_path.sv
tb_checker.sv
tb_cache_wt_path.sv

// ==== cache_wt_path.sv ====
`timescale 1ns/10ps

module cache_wt_path
   import cache_cfg_pkg::*, wbuf_pkg::*;
#(
   parameter int WBUF_DEPTH_W = 2,
   parameter int MEM_ADDR_W   = 6
) (
   input  logic                   clk_i,
   input  logic                   arst_i,

   // front-end write port
   input  logic                   fe_valid_i,
   input  logic [FE_WADDR_W-1:0]  fe_addr_i,  // word address
   input  logic [FE_NBYTES-1:0]   fe_wstrb_i,
   input  logic [FE_DATA_W-1:0]   fe_wdata_i,
   output logic                   fe_ack_o,

   // back-pressure and debug
   input  logic                   stall_i,
   input  logic [LINE_ADDR_W-1:0] dbg_addr_i,
   output logic [BE_DATA_W-1:0]   dbg_rdata_o,

   output logic                   wbuf_empty_o // nothing left to drain
);

   wbuf_entry_t push_entry;
   wbuf_entry_t head;
   logic        push;
   logic        pop;
   logic        not_empty;
   logic        ch_idle;

   logic                   be_valid;
   logic                   be_ready;
   logic [LINE_ADDR_W-1:0] be_addr;
   logic [BE_DATA_W-1:0]   be_wdata;
   logic [BE_NBYTES-1:0]   be_wstrb;

   assign push       = fe_valid_i & fe_ack_o;
   assign push_entry = '{addr: fe_addr_i, wstrb: fe_wstrb_i, data: fe_wdata_i};

   assign wbuf_empty_o = ch_idle & ~not_empty;

   wbuf_fifo #(
      .WBUF_DEPTH_W (WBUF_DEPTH_W)
   ) u_wbuf (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .push_i       (push),
      .push_entry_i (push_entry),
      .ack_o        (fe_ack_o),
      .pop_i        (pop),
      .head_o       (head),
      .not_empty_o  (not_empty)
   );

   wr_channel u_wr_ch (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .avail_i    (not_empty),
      .head_i     (head),
      .pop_o      (pop),
      .be_valid_o (be_valid),
      .be_addr_o  (be_addr),
      .be_wdata_o (be_wdata),
      .be_wstrb_o (be_wstrb),
      .be_ready_i (be_ready),
      .idle_o     (ch_idle)
   );

   be_mem #(
      .MEM_ADDR_W (MEM_ADDR_W)
   ) u_be_mem (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .valid_i     (be_valid),
      .addr_i      (be_addr),
      .wdata_i     (be_wdata),
      .wstrb_i     (be_wstrb),
      .ready_o     (be_ready),
      .stall_i     (stall_i),
      .dbg_addr_i  (dbg_addr_i),
      .dbg_rdata_o (dbg_rdata_o)
   );

endmodule

// ==== tb_cache_wt_path.sv ====
`timescale 1ns/10ps

module tb_cache_wt_path
   import cache_cfg_pkg::*;
();

   localparam int WBUF_DEPTH_W = 2;
   localparam int MEM_ADDR_W   = 6;
   localparam int NENT         = 30;
   localparam int RST_CYCLES   = 8;

   localparam logic [1:0] MODE_NONE = 2'd0;
   localparam logic [1:0] MODE_RAND = 2'd1;
   localparam logic [1:0] MODE_HOLD = 2'd2;

   logic                   clk;
   logic                   arst;
   logic                   fe_valid;
   logic [FE_WADDR_W-1:0]  fe_addr;
   logic [FE_NBYTES-1:0]   fe_wstrb;
   logic [FE_DATA_W-1:0]   fe_wdata;
   logic                   fe_ack;
   logic                   stall;
   logic [LINE_ADDR_W-1:0] dbg_addr;
   logic [BE_DATA_W-1:0]   dbg_rdata;
   logic                   wbuf_empty;
   logic                   hold_mode;
   logic                   check_req;
   logic                   check_ack;
   int                     err_cnt;
   int                     test_cnt;

   // stimulus table
   int                    tab_test  [NENT];
   logic [FE_WADDR_W-1:0] tab_addr  [NENT];
   logic [FE_NBYTES-1:0]  tab_wstrb [NENT];
   logic [FE_DATA_W-1:0]  tab_wdata [NENT];
   logic [1:0]            tab_mode  [NENT];

   integer seed = 32'h840f;
   int     n_ent;
   logic [31:0] rnd;

   always #10 clk = ~clk;

   cache_wt_path #(
      .WBUF_DEPTH_W (WBUF_DEPTH_W),
      .MEM_ADDR_W   (MEM_ADDR_W)
   ) DUT (
      .clk_i        (clk),
      .arst_i       (arst),
      .fe_valid_i   (fe_valid),
      .fe_addr_i    (fe_addr),
      .fe_wstrb_i   (fe_wstrb),
      .fe_wdata_i   (fe_wdata),
      .fe_ack_o     (fe_ack),
      .stall_i      (stall),
      .dbg_addr_i   (dbg_addr),
      .dbg_rdata_o  (dbg_rdata),
      .wbuf_empty_o (wbuf_empty)
   );

   tb_checker #(
      .WBUF_DEPTH_W (WBUF_DEPTH_W),
      .MEM_ADDR_W   (MEM_ADDR_W)
   ) u_checker (
      .clk_i        (clk),
      .arst_i       (arst),
      .fe_valid_i   (fe_valid),
      .fe_addr_i    (fe_addr),
      .fe_wstrb_i   (fe_wstrb),
      .fe_wdata_i   (fe_wdata),
      .fe_ack_i     (fe_ack),
      .stall_i      (stall),
      .wbuf_empty_i (wbuf_empty),
      .dbg_rdata_i  (dbg_rdata),
      .hold_mode_i  (hold_mode),
      .check_req_i  (check_req),
      .dbg_addr_o   (dbg_addr),
      .check_ack_o  (check_ack),
      .err_cnt_o    (err_cnt),
      .test_cnt_o   (test_cnt)
   );

   task automatic add_entry(input int t, input logic [FE_WADDR_W-1:0] a,
                            input logic [FE_NBYTES-1:0] s, input logic [FE_DATA_W-1:0] d,
                            input logic [1:0] m);
      tab_test[n_ent]  = t;
      tab_addr[n_ent]  = a;
      tab_wstrb[n_ent] = s;
      tab_wdata[n_ent] = d;
      tab_mode[n_ent]  = m;
      n_ent++;
   endtask

   task automatic build_table();
      // lanes of line 1, then lane 1 again
      add_entry(1, 14'h004, 4'hf, 32'h1111_1111, MODE_NONE);
      add_entry(1, 14'h005, 4'hf, 32'h2222_2222, MODE_NONE);
      add_entry(1, 14'h006, 4'hf, 32'h3333_3333, MODE_NONE);
      add_entry(1, 14'h007, 4'hf, 32'h4444_4444, MODE_NONE);
      add_entry(1, 14'h005, 4'hf, 32'hdead_beef, MODE_NONE);
      add_entry(2, 14'h009, 4'h3, 32'haaaa_1234, MODE_NONE); // disjoint halves
      add_entry(2, 14'h009, 4'hc, 32'h5678_bbbb, MODE_NONE);
      add_entry(3, 14'h00c, 4'hf, 32'h0000_0001, MODE_NONE);
      add_entry(3, 14'h00c, 4'hf, 32'h0000_0002, MODE_NONE);
      add_entry(3, 14'h00c, 4'hf, 32'h0000_0003, MODE_NONE);
      for (int k = 0; k < 8; k++) begin
         add_entry(4, 14'h010 + 14'(k), 4'hf, 32'hc0de_0000 + 32'(k), MODE_HOLD);
      end
      for (int k = 0; k < 12; k++) begin
         rnd = $random(seed);
         add_entry(5, {6'd0, rnd[7:0]}, rnd[11:8], $random(seed), MODE_RAND);
      end
   endtask

   task automatic request_check();
      check_req <= 1'b1;
      do @(posedge clk); while (!check_ack);
      check_req <= 1'b0;
      do @(posedge clk); while (check_ack);
   endtask

   // drive one write at the current edge and hold it until taken
   task automatic send_write(input int i, inout logic released);
      fe_valid  <= 1'b1;
      fe_addr   <= tab_addr[i];
      fe_wstrb  <= tab_wstrb[i];
      fe_wdata  <= tab_wdata[i];
      hold_mode <= (tab_mode[i] == MODE_HOLD);
      if (tab_mode[i] == MODE_HOLD) begin
         stall <= ~released;
      end else if (tab_mode[i] == MODE_RAND) begin
         rnd = $random(seed);
         stall <= rnd[0];
      end else begin
         stall <= 1'b0;
      end
      forever begin
         @(posedge clk);
         if (fe_ack) break;
         if (tab_mode[i] == MODE_HOLD) begin
            stall    <= 1'b0; // buffer full, let it drain
            released = 1'b1;
         end else if (tab_mode[i] == MODE_RAND) begin
            rnd = $random(seed);
            stall <= rnd[0];
         end
      end
   endtask

   // watchdog
   initial begin
      repeat (NENT * 40 + RST_CYCLES) @(posedge clk);
      $display("timeout, the run did not finish in time");
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      logic released;
      clk       = 1'b0;
      arst      = 1'b1;
      fe_valid  = 1'b0;
      fe_addr   = '0;
      fe_wstrb  = '0;
      fe_wdata  = '0;
      stall     = 1'b0;
      hold_mode = 1'b0;
      check_req = 1'b0;
      n_ent     = 0;
      released  = 1'b0;
      build_table();

      repeat (RST_CYCLES) @(posedge clk);
      arst <= 1'b0;
      @(posedge clk);
      request_check(); // state right after reset

      for (int i = 0; i < NENT; i++) begin
         send_write(i, released);
         if (i == NENT - 1 || tab_test[i+1] != tab_test[i]) begin
            fe_valid  <= 1'b0;
            stall     <= 1'b0;
            hold_mode <= 1'b0;
            released  = 1'b0;
            do @(posedge clk); while (!wbuf_empty);
            request_check();
         end
      end

      $display("tests %0d, errors %0d", test_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/10ps

module tb_checker
   import cache_cfg_pkg::*;
#(
   parameter int WBUF_DEPTH_W = 2,
   parameter int MEM_ADDR_W   = 6
) (
   input  logic                   clk_i,
   input  logic                   arst_i,
   input  logic                   fe_valid_i,
   input  logic [FE_WADDR_W-1:0]  fe_addr_i,
   input  logic [FE_NBYTES-1:0]   fe_wstrb_i,
   input  logic [FE_DATA_W-1:0]   fe_wdata_i,
   input  logic                   fe_ack_i,
   input  logic                   stall_i,
   input  logic                   wbuf_empty_i,
   input  logic [BE_DATA_W-1:0]   dbg_rdata_i,
   input  logic                   hold_mode_i,
   input  logic                   check_req_i,
   output logic [LINE_ADDR_W-1:0] dbg_addr_o,
   output logic                   check_ack_o,
   output int                     err_cnt_o,
   output int                     test_cnt_o
);

   localparam int NLINES   = 2 ** MEM_ADDR_W;
   localparam int FILL_EXP = 2 ** WBUF_DEPTH_W + 1; // buffer plus channel register

   logic [BE_DATA_W-1:0] img [NLINES];

   int   mon_errs;
   int   chk_errs;
   int   errs_done;
   int   stall_cnt;
   logic hold_seen;
   logic full_checked;
   logic req_q;

   assign err_cnt_o = mon_errs + chk_errs;

   // reference image and fill count under held stall
   always @(posedge clk_i or posedge arst_i) begin
      int line;
      int lane;
      if (arst_i) begin
         for (int l = 0; l < NLINES; l++) begin
            img[l] = '0;
         end
         mon_errs     = 0;
         stall_cnt    = 0;
         hold_seen    = 1'b0;
         full_checked = 1'b0;
         req_q        = 1'b0;
      end else begin
         if (fe_valid_i && fe_ack_i) begin
            line = int'(fe_addr_i[LANE_W +: MEM_ADDR_W]);
            lane = int'(fe_addr_i[LANE_W-1:0]);
            for (int b = 0; b < FE_NBYTES; b++) begin
               if (fe_wstrb_i[b]) begin
                  img[line][(lane*FE_NBYTES + b)*8 +: 8] = fe_wdata_i[b*8 +: 8];
               end
            end
         end
         if (hold_mode_i && stall_i) begin
            hold_seen = 1'b1;
            if (!fe_ack_i && !full_checked) begin
               full_checked = 1'b1;
               if (stall_cnt != FILL_EXP) begin
                  mon_errs++;
                  $display("buffer filled after %0d writes under stall, expected %0d",
                           stall_cnt, FILL_EXP);
               end
            end else if (fe_valid_i && fe_ack_i) begin
               stall_cnt++;
            end
         end else begin
            stall_cnt = 0;
         end
         if (check_req_i && !req_q) begin
            if (hold_seen && !full_checked) begin
               mon_errs++;
               $display("buffer never filled while stall was held");
            end
            hold_seen    = 1'b0;
            full_checked = 1'b0;
         end
         req_q = check_req_i;
      end
   end

   // walks every line through the debug port
   task automatic compare_lines();
      if (!wbuf_empty_i || !fe_ack_i) begin
         chk_errs++;
         $display("write path not drained or not ready at check time");
      end
      dbg_addr_o <= '0;
      for (int l = 0; l < NLINES; l++) begin
         @(posedge clk_i);
         if (dbg_rdata_i !== img[l]) begin
            chk_errs++;
            $display("Fail dbg_rdata_o line %0d: expected %h, got %h", l, img[l], dbg_rdata_i);
         end
         dbg_addr_o <= LINE_ADDR_W'(l + 1);
      end
      test_cnt_o++;
      $display("test %0d done, %0d errors", test_cnt_o, chk_errs + mon_errs - errs_done);
      errs_done = chk_errs + mon_errs;
   endtask

   initial begin
      dbg_addr_o  = '0;
      check_ack_o = 1'b0;
      chk_errs    = 0;
      errs_done   = 0;
      test_cnt_o  = 0;
      forever begin
         @(posedge clk_i);
         if (check_req_i && !check_ack_o) begin
            compare_lines();
            check_ack_o <= 1'b1;
         end else if (!check_req_i) begin
            check_ack_o <= 1'b0;
         end
      end
   end

endmodule

// ==== wbuf_fifo.sv ====
`timescale 1ns/10ps

module wbuf_fifo
   import wbuf_pkg::*;
#(
   parameter int WBUF_DEPTH_W = 2
) (
   input  logic        clk_i,
   input  logic        arst_i,

   // write side
   input  logic        push_i,
   input  wbuf_entry_t push_entry_i,
   output logic        ack_o,

   // read side
   input  logic        pop_i,
   output wbuf_entry_t head_o,
   output logic        not_empty_o
);

   localparam int DEPTH = 2 ** WBUF_DEPTH_W;

   wbuf_entry_t mem_q [DEPTH];

   logic [WBUF_DEPTH_W-1:0] wr_ptr_q;
   logic [WBUF_DEPTH_W-1:0] rd_ptr_q;
   logic [WBUF_DEPTH_W:0]   count_q;

   logic full;
   logic do_push;
   logic do_pop;

   assign full        = (count_q == (WBUF_DEPTH_W+1)'(DEPTH));
   assign ack_o       = ~full;
   assign not_empty_o = (count_q != '0);

   // a full buffer still takes a push when the head leaves in the same cycle
   assign do_pop  = pop_i & not_empty_o;
   assign do_push = push_i & (~full | do_pop);

   assign head_o = mem_q[rd_ptr_q];

   // entry storage
   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem_q[wr_ptr_q] <= push_entry_i;
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         count_q <= '0;
      end else begin
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q; // both or neither
         endcase
      end
   end

endmodule

// ==== wbuf_pkg.sv ====
package wbuf_pkg;

   import cache_cfg_pkg::*;

   // one buffered front-end write
   typedef struct packed {
      logic [FE_WADDR_W-1:0] addr;  // word address
      logic [FE_NBYTES-1:0]  wstrb; // byte strobe within the word
      logic [FE_DATA_W-1:0]  data;
   } wbuf_entry_t;

   // addr splits into line address and lane:
   //   addr[FE_WADDR_W-1:LANE_W]  line
   //   addr[LANE_W-1:0]           lane within the back-end line
   //
   // data is the unshifted word, the channel replicates it across lanes
   // and moves the strobe to the addressed lane

endpackage

// ==== wr_channel.sv ====
`timescale 1ns/10ps

module wr_channel
   import cache_cfg_pkg::*, wbuf_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   arst_i,

   // write buffer head
   input  logic                   avail_i,
   input  wbuf_entry_t            head_i,
   output logic                   pop_o,

   // back-end bus
   output logic                   be_valid_o,
   output logic [LINE_ADDR_W-1:0] be_addr_o,
   output logic [BE_DATA_W-1:0]   be_wdata_o,
   output logic [BE_NBYTES-1:0]   be_wstrb_o,
   input  logic                   be_ready_i,

   output logic                   idle_o
);

   localparam int NLANES = 2 ** LANE_W;

   typedef enum logic {
      ST_IDLE  = 1'b0,
      ST_WRITE = 1'b1
   } state_t;

   state_t state_q;
   state_t state_d;

   wbuf_entry_t hold_q;       // entry being written
   logic        load;
   logic [LANE_W-1:0] lane;

   // next state and pop
   always_comb begin
      state_d = state_q;
      load    = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (avail_i) begin
               load    = 1'b1;
               state_d = ST_WRITE;
            end
         end
         default: begin // write
            if (be_ready_i) begin
               if (avail_i) begin
                  load = 1'b1; // completion and next pop together
               end else begin
                  state_d = ST_IDLE;
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         hold_q <= head_i;
      end
   end

   assign pop_o      = load;
   assign idle_o     = (state_q == ST_IDLE);
   assign be_valid_o = (state_q == ST_WRITE); // held until be_ready_i

   // line address drops the lane bits
   assign lane      = hold_q.addr[LANE_W-1:0];
   assign be_addr_o = hold_q.addr[FE_WADDR_W-1:LANE_W];

   assign be_wdata_o = {NLANES{hold_q.data}}; // word copied to every lane

   // strobe moved to the addressed lane only
   always_comb begin
      be_wstrb_o = '0;
      if (state_q == ST_WRITE) begin
         be_wstrb_o = {{(BE_NBYTES-FE_NBYTES){1'b0}}, hold_q.wstrb} << (lane * FE_NBYTES);
      end
   end

endmodule
